//--- Makefile
SIM      = verilator
FLAGS    = --binary --assert --timing -j 0
TOP      = gpioTb
FILELIST = tb.f
BUILDDIR = obj_dir
SRCS     = $(shell grep -v '^+' $(FILELIST))
BIN      = $(BUILDDIR)/V$(TOP)
STIM     = gpioStim.txt
LOG      = sim.log

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILDDIR) -f $(FILELIST)

run: $(BIN) $(STIM)
	./$(BIN) | tee $(LOG)
	@! grep -q "FAIL: see errors above" $(LOG)
	@grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)

//--- gpioCsr.sv
/*
 * GPIO control and status registers
 * Decodes the slave bus address into write strobes, holds output level,
 * direction and alternate mode per pin, and returns a registered read word
 * including the synchronized pad inputs
 */
`timescale 1ns/10ps

module gpioCsr
	import gpioPkg::*;
#(
	parameter logic [cBlockWidth-1:0] pAdrsMap   = 8'h01,
	parameter int                     pGpioWidth = 5
)
(
	input  logic                    iSCLK,
	input  logic                    iSRST,
	// Slave bus
	input  usiAdrsU                 iUsiAdrs,
	input  logic [cUsiBusWidth-1:0] iUsiWd,
	output logic [cUsiBusWidth-1:0] oUsiRd,
	// Pad side read-back
	input  logic [pGpioWidth-1:0]   gpioInSync,
	// Control registers out to the pad block
	output logic [pGpioWidth-1:0]   gpioOutCtrl,
	output logic [pGpioWidth-1:0]   gpioDir,
	output logic [pGpioWidth-1:0]   gpioAltMode
);

	// Zero padding for read-back
	localparam int cPadWidth = cUsiBusWidth - pGpioWidth;

	logic                    blockHit;
	logic                    wrEn;
	logic                    wrOutCtrl;
	logic                    wrDir;
	logic                    wrAltMode;
	logic [cUsiBusWidth-1:0] rdNext;

	// ----------------------------------------------------------------------
	// Address decode
	// ----------------------------------------------------------------------
	// This instance owns the addressed block
	assign blockHit  = (iUsiAdrs.field.block == pAdrsMap);
	assign wrEn      = iUsiAdrs.field.wrFlag && blockHit;

	// One strobe per writable offset
	assign wrOutCtrl = wrEn && (iUsiAdrs.field.offset == cOffOutCtrl);
	assign wrDir     = wrEn && (iUsiAdrs.field.offset == cOffDir);
	assign wrAltMode = wrEn && (iUsiAdrs.field.offset == cOffAltMode);

	// ----------------------------------------------------------------------
	// Control registers
	// ----------------------------------------------------------------------
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			// Pads start as inputs, pins owned by the alternate source
			gpioOutCtrl <= '0;
			gpioDir     <= '1;
			gpioAltMode <= '1;
		end
		else
		begin
			if (wrOutCtrl)
				gpioOutCtrl <= iUsiWd[pGpioWidth-1:0];
			if (wrDir)
				gpioDir <= iUsiWd[pGpioWidth-1:0];
			if (wrAltMode)
				gpioAltMode <= iUsiWd[pGpioWidth-1:0];
		end
	end

	// ----------------------------------------------------------------------
	// Read-back
	// ----------------------------------------------------------------------
	// Read mux, write flag ignored
	always_comb
	begin
		rdNext = '0;
		if (blockHit)
		begin
			case (iUsiAdrs.field.offset)
				cOffOutCtrl: rdNext = {{cPadWidth{1'b0}}, gpioOutCtrl};
				cOffDir:     rdNext = {{cPadWidth{1'b0}}, gpioDir};
				cOffAltMode: rdNext = {{cPadWidth{1'b0}}, gpioAltMode};
				cOffGpioIn:  rdNext = {{cPadWidth{1'b0}}, gpioInSync};
				// Unmapped offsets read as zero
				default:     rdNext = '0;
			endcase
		end
	end

	// Data returned one cycle after the address
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
			oUsiRd <= '0;
		else
			oUsiRd <= rdNext;
	end

	// ----------------------------------------------------------------------
	// Checks
	// ----------------------------------------------------------------------
	// Offsets are distinct, so one register per write cycle
	assert property (@(posedge iSCLK) disable iff (iSRST)
		$onehot0({wrOutCtrl, wrDir, wrAltMode}));

	// Read word stays known, pad inputs included
	assert property (@(posedge iSCLK) disable iff (iSRST)
		!$isunknown(oUsiRd));

endmodule

//--- gpioPkg.sv
/*
 * GPIO shared definitions
 * Bus widths, register offsets and the slave address word layout
 */
package gpioPkg;

	// ----------------------------------------------------------------------
	// Bus geometry
	// ----------------------------------------------------------------------
	localparam int cUsiBusWidth = 32;
	localparam int cBlockWidth  = 8;
	localparam int cOffsetWidth = 16;

	// Register offsets within a block
	localparam logic [cOffsetWidth-1:0] cOffOutCtrl = 16'h0000;
	localparam logic [cOffsetWidth-1:0] cOffDir     = 16'h0004;
	localparam logic [cOffsetWidth-1:0] cOffAltMode = 16'h0008;
	// Read only, synchronized pad levels
	localparam logic [cOffsetWidth-1:0] cOffGpioIn  = 16'h0040;

	// ----------------------------------------------------------------------
	// Address word, seen raw or split into fields
	// ----------------------------------------------------------------------
	typedef union packed
	{
		logic [cUsiBusWidth-1:0] raw;
		struct packed
		{
			// Bit 31, not decoded
			logic                    rsvd;
			// Bit 30, write marker
			logic                    wrFlag;
			// Bits 29..24
			logic [5:0]              spare;
			logic [cBlockWidth-1:0]  block;
			logic [cOffsetWidth-1:0] offset;
		} field;
	} usiAdrsU;

endpackage

//--- gpioPort.sv
/*
 * GPIO pad block
 * Picks pad output and enable per pin from the control registers or the
 * alternate function, and brings pad inputs into the clock domain
 */
`timescale 1ns/10ps

module gpioPort
#(
	parameter int pGpioWidth = 5
)
(
	input  logic                  iSCLK,
	input  logic                  iSRST,
	// From the register block
	input  logic [pGpioWidth-1:0] gpioOutCtrl,
	input  logic [pGpioWidth-1:0] gpioDir,
	input  logic [pGpioWidth-1:0] gpioAltMode,
	// Alternate function source
	input  logic [pGpioWidth-1:0] iAltOut,
	input  logic [pGpioWidth-1:0] iAltOe,
	// Pads
	input  logic [pGpioWidth-1:0] iPadIn,
	output logic [pGpioWidth-1:0] oPadOut,
	output logic [pGpioWidth-1:0] oPadOe,
	// Synchronized input level
	output logic [pGpioWidth-1:0] gpioInSync,
	output logic [pGpioWidth-1:0] oAltIn
);

	// Synchronizer stages
	logic [pGpioWidth-1:0] padMeta;
	logic [pGpioWidth-1:0] padSync;

	// ----------------------------------------------------------------------
	// Output path
	// ----------------------------------------------------------------------
	// Purely combinational, a register write shows on the pads next cycle
	always_comb
	begin
		for (int i = 0; i < pGpioWidth; i++)
		begin
			if (gpioAltMode[i])
			begin
				// Pin handed to the alternate function
				oPadOut[i] = iAltOut[i];
				oPadOe[i]  = iAltOe[i];
			end
			else
			begin
				// Direction 1 is input, so enable is inverted
				oPadOut[i] = gpioOutCtrl[i];
				oPadOe[i]  = ~gpioDir[i];
			end
		end
	end

	// ----------------------------------------------------------------------
	// Input path
	// ----------------------------------------------------------------------
	// Two flops against metastability
	always_ff @(posedge iSCLK)
	begin
		if (iSRST)
		begin
			padMeta <= '0;
			padSync <= '0;
		end
		else
		begin
			padMeta <= iPadIn;
			padSync <= padMeta;
		end
	end

	// Same level feeds read-back and alternate function
	assign gpioInSync = padSync;
	assign oAltIn     = padSync;

	// ----------------------------------------------------------------------
	// Checks
	// ----------------------------------------------------------------------
	// Register-owned output pin must drive its pad
	assert property (@(posedge iSCLK) disable iff (iSRST)
		((~gpioAltMode & ~gpioDir & ~oPadOe) == '0));

endmodule

//--- gpioStim.txt
# op adrs data expect, all hex; W write, R read oUsiRd, P pad level, expect oAltIn
# A uses adrs as iAltOut and data as iAltOe; C expect is {oPadOut,oPadOe}
R 00010000 00000000 00000000
R 00010004 00000000 0000001F
R 00010008 00000000 0000001F
C 00000000 00000000 00000000
W 40010008 00000000 00000000
R 00010008 00000000 00000000
C 00000000 00000000 00000000
W 40010000 FFFFFFEA 00000000
R 00010000 00000000 0000000A
W 40010004 00000013 00000000
R 00010004 00000000 00000013
C 00000000 00000000 0000014C
A 00000015 00000007 00000000
W 40010008 00000003 00000000
R 00010008 00000000 00000003
C 00000000 00000000 0000012F
P 00000000 00000016 00000016
R 00010040 00000000 00000016
P 00000000 00000009 00000009
R 00010040 00000000 00000009
W 00010000 0000001F 00000000
R 00010000 00000000 0000000A
W 40020004 00000000 00000000
R 00010004 00000000 00000013
R 00020000 00000000 00000000
R 0001000C 00000000 00000000
W 4001000C 0000001F 00000000
C 00000000 00000000 0000012F
W 40010004 FFFFFFFF 00000000
R 00010004 00000000 0000001F
C 00000000 00000000 00000123
W 40010008 00000000 00000000
W 40010004 00000005 00000000
C 00000000 00000000 0000015A

//--- gpioTb.sv
/*
 * GPIO subsystem testbench
 * Replays bus, pad and alternate-function operations from a stimulus file
 * and checks read data, pad levels and synchronized inputs
 */
`timescale 1ns/10ps

module gpioTb
	import gpioPkg::*;
;

	localparam logic [cBlockWidth-1:0] cBlock = 8'h01;
	localparam int cPins = 5;
	// About 35 lines of at most 4 cycles each, plus reset, with margin
	localparam int cMaxCycles = 400;

	logic                    iSCLK;
	logic                    iSRST;
	usiAdrsU                 usiAdrs;
	logic [cUsiBusWidth-1:0] usiWd;
	logic [cUsiBusWidth-1:0] usiRd;
	logic [cPins-1:0]        padIn;
	logic [cPins-1:0]        padOut;
	logic [cPins-1:0]        padOe;
	logic [cPins-1:0]        altOut;
	logic [cPins-1:0]        altOe;
	logic [cPins-1:0]        altIn;

	int errCnt = 0;
	int chkCnt = 0;
	int cycleCnt = 0;
	int lineNo = 0;

	gpioTop #(
		.pAdrsMap   (cBlock),
		.pGpioWidth (cPins)
	) i_gpioTop (
		.iSCLK    (iSCLK),
		.iSRST    (iSRST),
		.iUsiAdrs (usiAdrs),
		.iUsiWd   (usiWd),
		.oUsiRd   (usiRd),
		.iPadIn   (padIn),
		.oPadOut  (padOut),
		.oPadOe   (padOe),
		.iAltOut  (altOut),
		.iAltOe   (altOe),
		.oAltIn   (altIn)
	);

	// ----------------------------------------------------------------------
	// Clock and run limit
	// ----------------------------------------------------------------------
	initial
	begin
		iSCLK = 1'b0;
		forever #5 iSCLK = ~iSCLK;
	end

	always @(posedge iSCLK)
	begin
		cycleCnt++;
		if (cycleCnt >= cMaxCycles)
		begin
			$display("Timeout: run stopped after %0d cycles, %0d errors", cycleCnt, errCnt);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// ----------------------------------------------------------------------
	// Operations, each entered 1 ns after a rising edge
	// ----------------------------------------------------------------------
	// One write cycle, register updated at the next edge
	task automatic busWrite(input logic [31:0] adrs, input logic [31:0] data);
		usiAdrs.raw = adrs;
		usiWd = data;
		@(posedge iSCLK);
		#1;
		usiAdrs.raw = '0;
		usiWd = '0;
	endtask

	// Read data is registered one edge after the address
	task automatic busRead(input logic [31:0] adrs, input logic [31:0] expVal);
		usiAdrs.raw = adrs;
		@(posedge iSCLK);
		#1;
		usiAdrs.raw = '0;
		chkCnt++;
		assert (usiRd === expVal)
		else
		begin
			$display("** Error: oUsiRd = %h, expected %h (line %0d)", usiRd, expVal, lineNo);
			errCnt++;
		end
	endtask

	// Three idle cycles cover the two-flop synchronizer
	task automatic setPadLevel(input logic [cPins-1:0] level, input logic [cPins-1:0] expIn);
		padIn = level;
		repeat (3)
		begin
			@(posedge iSCLK);
			#1;
		end
		chkCnt++;
		assert (altIn === expIn)
		else
		begin
			$display("** Error: oAltIn = %h, expected %h (line %0d)", altIn, expIn, lineNo);
			errCnt++;
		end
	endtask

	task automatic setAltSource(input logic [cPins-1:0] outVal, input logic [cPins-1:0] oeVal);
		altOut = outVal;
		altOe = oeVal;
		// Let the combinational pad path settle
		@(posedge iSCLK);
		#1;
	endtask

	task automatic checkPads(input logic [2*cPins-1:0] expPads);
		chkCnt++;
		assert ({padOut, padOe} === expPads)
		else
		begin
			$display("** Error: {oPadOut,oPadOe} = %h, expected %h (line %0d)",
				{padOut, padOe}, expPads, lineNo);
			errCnt++;
		end
	endtask

	task automatic applyOp(input logic [7:0] op, input logic [31:0] adrs,
		input logic [31:0] data, input logic [31:0] expVal);
		case (op)
			"W": busWrite(adrs, data);
			"R": busRead(adrs, expVal);
			"P": setPadLevel(data[cPins-1:0], expVal[cPins-1:0]);
			"A": setAltSource(adrs[cPins-1:0], data[cPins-1:0]);
			"C": checkPads(expVal[2*cPins-1:0]);
			default:
			begin
				$display("Unknown operation on stimulus line %0d", lineNo);
				errCnt++;
			end
		endcase
	endtask

	// ----------------------------------------------------------------------
	// Stimulus file
	// ----------------------------------------------------------------------
	task automatic runStimulus();
		int fd;
		int nItems;
		string line;
		logic [7:0] op;
		logic [31:0] adrs;
		logic [31:0] data;
		logic [31:0] expVal;
		fd = $fopen("gpioStim.txt", "r");
		if (fd == 0)
		begin
			$display("Cannot open the stimulus file gpioStim.txt");
			errCnt++;
		end
		else
		begin
			while (!$feof(fd))
			begin
				line = "";
				void'($fgets(line, fd));
				lineNo++;
				// Skip blank and comment lines
				if (line.len() > 1 && line[0] != "#")
				begin
					nItems = $sscanf(line, "%c %h %h %h", op, adrs, data, expVal);
					if (nItems != 4)
					begin
						$display("Malformed stimulus line %0d", lineNo);
						errCnt++;
					end
					else
						applyOp(op, adrs, data, expVal);
				end
			end
			$fclose(fd);
		end
	endtask

	// ----------------------------------------------------------------------
	// Main sequence
	// ----------------------------------------------------------------------
	initial
	begin
		iSRST = 1'b1;
		usiAdrs.raw = '0;
		usiWd = '0;
		padIn = '0;
		altOut = '0;
		altOe = '0;
		repeat (10) @(posedge iSCLK);
		#1;
		iSRST = 1'b0;
		runStimulus();
		$display("Run complete: %0d checks, %0d errors", chkCnt, errCnt);
		if (errCnt == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

//--- gpioTop.sv
/*
 * GPIO subsystem top
 * Joins the register block on the slave bus to the pad block
 */
`timescale 1ns/10ps

module gpioTop
	import gpioPkg::*;
#(
	parameter logic [cBlockWidth-1:0] pAdrsMap   = 8'h01,
	parameter int                     pGpioWidth = 5
)
(
	input  logic                    iSCLK,
	input  logic                    iSRST,
	// Slave bus
	input  usiAdrsU                 iUsiAdrs,
	input  logic [cUsiBusWidth-1:0] iUsiWd,
	output logic [cUsiBusWidth-1:0] oUsiRd,
	// Pads
	input  logic [pGpioWidth-1:0]   iPadIn,
	output logic [pGpioWidth-1:0]   oPadOut,
	output logic [pGpioWidth-1:0]   oPadOe,
	// Alternate function
	input  logic [pGpioWidth-1:0]   iAltOut,
	input  logic [pGpioWidth-1:0]   iAltOe,
	output logic [pGpioWidth-1:0]   oAltIn
);

	// Register block to pad block
	logic [pGpioWidth-1:0] gpioOutCtrl;
	logic [pGpioWidth-1:0] gpioDir;
	logic [pGpioWidth-1:0] gpioAltMode;
	// Pad block back to register block
	logic [pGpioWidth-1:0] gpioInSync;

	gpioCsr #(
		.pAdrsMap   (pAdrsMap),
		.pGpioWidth (pGpioWidth)
	) i_gpioCsr (
		.iSCLK       (iSCLK),
		.iSRST       (iSRST),
		.iUsiAdrs    (iUsiAdrs),
		.iUsiWd      (iUsiWd),
		.oUsiRd      (oUsiRd),
		.gpioInSync  (gpioInSync),
		.gpioOutCtrl (gpioOutCtrl),
		.gpioDir     (gpioDir),
		.gpioAltMode (gpioAltMode)
	);

	gpioPort #(
		.pGpioWidth (pGpioWidth)
	) i_gpioPort (
		.iSCLK       (iSCLK),
		.iSRST       (iSRST),
		.gpioOutCtrl (gpioOutCtrl),
		.gpioDir     (gpioDir),
		.gpioAltMode (gpioAltMode),
		.iAltOut     (iAltOut),
		.iAltOe      (iAltOe),
		.iPadIn      (iPadIn),
		.oPadOut     (oPadOut),
		.oPadOe      (oPadOe),
		.gpioInSync  (gpioInSync),
		.oAltIn      (oAltIn)
	);

endmodule

//--- tb.f
gpioPkg.sv
gpioCsr.sv
gpioPort.sv
gpioTop.sv
gpioTb.sv
